//--- Makefile
VERILATOR  = verilator
TOP        = tb_vga_top
FILELIST   = sim.f
LOG        = sim.log
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/100ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- sim.f
source/video_timing_pkg.sv
source/video_cmd_pkg.sv
source/vga_timing.sv
source/ring_render.sv
source/led_dimmer.sv
source/video_ctrl.sv
source/vga_top.sv
sim/tb_vga_top.sv

//--- sim/tb_vga_top.sv
module tb_vga_top import video_timing_pkg::*, video_cmd_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int frame_cycles = 800 * 521;

  logic                  pixclk;
  logic                  reset;
  logic                  cmd_req;
  cmd_op_e               cmd_op;
  logic [cmd_data_w-1:0] cmd_data;
  logic                  cmd_ack;
  logic                  hsync;
  logic                  vsync;
  logic [1:0]            color;
  logic [2:0]            led;

  int          mismatches;
  int          proto_errs;
  int          timeouts;
  bit          aborted;  // set by the first timeout, ends all waits
  logic [31:0] lfsr;

  // output raster position, rebuilt from the delayed syncs
  int   out_hc;
  int   out_vc;
  int   out_frame;
  logic hs_prev;
  logic vs_prev;
  logic ack_prev;
  logic req_prev;  // req as seen by the posedge that follows

  // reference model of pending and active control state
  int         pend_cx;
  int         pend_cy;
  int         pend_speed;
  bit         pend_run;
  int         act_cx;
  int         act_cy;
  int         model_phase;
  logic [1:0] grid_now [64];
  logic [1:0] grid_prev [64];
  int         duty_now [3];
  int         duty_prev [3];

  vga_top DUT (.*);

  always #20 pixclk = ~pixclk;  // 40 ns period

  // ------------------------------------------------------------------------
  // output monitor, everything is stable at the falling edge
  // ------------------------------------------------------------------------
  always @(negedge pixclk) begin
    if (reset) begin
      out_hc    = -1;  // unknown until the first hsync fall
      out_vc    = -1;
      out_frame = 0;
      hs_prev   = 1'b1;
      vs_prev   = 1'b1;
      ack_prev  = 1'b0;
      req_prev  = 1'b0;
    end else begin
      // req_prev holds the req level on the edge where ack went high
      assert (!(cmd_ack && !ack_prev && !req_prev)) else begin
        proto_errs++;
        $display("cmd_ack rose while cmd_req was low");
      end
      if (!hsync && hs_prev) begin
        out_hc = 0;
        if (!vsync && vs_prev) begin
          out_vc      = 0;
          out_frame   = out_frame + 1;
          act_cx      = pend_cx;  // frame start commit
          act_cy      = pend_cy;
          if (pend_run)
            model_phase = (model_phase + pend_speed) % 65536;  // new speed counts
        end else if (out_vc >= 0) begin
          out_vc = out_vc + 1;
        end
      end else if (out_hc >= 0) begin
        out_hc = out_hc + 1;
      end
      hs_prev  = hsync;
      vs_prev  = vsync;
      ack_prev = cmd_ack;
      req_prev = cmd_req;
    end
  end

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v    = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  // ring color from the pixel, center and phase
  function automatic logic [1:0] ring_color(input int px, input int py, input int cx,
                                            input int cy, input int ph);
    int dx;
    int dy;
    int r2;
    dx = px - cx;
    dy = py - cy;
    r2 = dx * dx + dy * dy - (ph << phase_shift);  // bits 13:12 same as mod 2^16
    return {r2[13], r2[12]};
  endfunction

  task automatic report_mismatch(input string name, input int exp, input int got);
    mismatches++;
    $display("Mismatch %s: expected %0d, actual %0d", name, exp, got);
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    aborted = 1'b1;
    $display("timeout: no %s within the allowed number of cycles", what);
  endtask

  // ------------------------------------------------------------------------
  // waits
  // ------------------------------------------------------------------------
  task automatic wait_pixel(input int hc, input int vc);
    int n;
    n = 0;
    while (!aborted && !(out_hc == hc && out_vc == vc) && n < 2 * frame_cycles) begin
      @(negedge pixclk);
      #1;
      n++;
    end
    if (!aborted && !(out_hc == hc && out_vc == vc))
      note_timeout("pixel position");
  endtask

  task automatic cycles_until(input bit on_vsync, input logic level, input int limit,
                              output int n);
    n = 0;
    while (!aborted && (on_vsync ? vsync : hsync) !== level && n < limit) begin
      @(negedge pixclk);
      #1;
      n++;
    end
    if (!aborted && (on_vsync ? vsync : hsync) !== level)
      note_timeout(on_vsync ? "vsync edge" : "hsync edge");
  endtask

  // full four-phase cycle, checks ack latency both ways
  task automatic send_cmd(input cmd_op_e op, input int data, input string name);
    int n;
    if (aborted) return;
    @(posedge pixclk);
    #2;
    cmd_op   = op;
    cmd_data = data[cmd_data_w-1:0];
    cmd_req  = 1'b1;
    n = 0;
    while (!aborted && !cmd_ack && n < 16) begin
      @(posedge pixclk);
      #1;
      n++;
    end
    if (!cmd_ack) begin
      note_timeout("cmd_ack rise");
      return;
    end
    assert (n == 2) else report_mismatch({name, "_ack_rise"}, 2, n);
    case (op)  // latched into pending on the decode edge
      op_center_x: pend_cx = data;
      op_center_y: pend_cy = data;
      op_speed:    pend_speed = data % 256;
      op_freeze:   pend_run = 1'b0;
      op_run:      pend_run = 1'b1;
      default:     ;
    endcase
    #1;
    cmd_req = 1'b0;
    n = 0;
    while (!aborted && cmd_ack && n < 16) begin
      @(posedge pixclk);
      #1;
      n++;
    end
    if (cmd_ack)
      note_timeout("cmd_ack fall");
    assert (n == 1) else report_mismatch({name, "_ack_fall"}, 1, n);
  endtask

  // ------------------------------------------------------------------------
  // pixel and led checks
  // ------------------------------------------------------------------------
  task automatic sample_grid(input string name, input int row_lo, input int row_hi);
    int         px;
    int         py;
    logic [1:0] expect_c;
    for (int j = 0; j < 8; j++) begin
      for (int i = 0; i < 8; i++) begin
        px = 13 + i * 87;  // raster order, one frame
        py = row_lo + j * (row_hi - row_lo) / 7;
        wait_pixel(h_start + px, v_start + py);
        if (aborted) return;
        expect_c = ring_color(px, py, act_cx, act_cy, model_phase);
        grid_now[j * 8 + i] = color;
        assert (color == expect_c) else report_mismatch(name, expect_c, color);
      end
    end
  endtask

  // one pwm period, high count equals the phase field
  task automatic measure_led_duty(input string name);
    int cnt [3];
    int field [3];
    field[0] = (model_phase >> 5) & 255;
    field[1] = (model_phase >> 6) & 255;
    field[2] = (model_phase >> 7) & 255;
    cnt = '{0, 0, 0};
    for (int k = 0; k < 256; k++) begin
      @(negedge pixclk);
      #1;
      for (int b = 0; b < 3; b++) begin
        if (led[b]) cnt[b]++;
      end
    end
    for (int b = 0; b < 3; b++) begin
      duty_now[b] = cnt[b];
      assert (cnt[b] == field[b]) else report_mismatch(name, field[b], cnt[b]);
    end
  endtask

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------
  task automatic check_reset_outputs();
    assert (hsync === 1'b1) else report_mismatch("reset_hsync", 1, hsync);
    assert (vsync === 1'b1) else report_mismatch("reset_vsync", 1, vsync);
    assert (color === 2'b00) else report_mismatch("reset_color", 0, color);
    assert (cmd_ack === 1'b0) else report_mismatch("reset_ack", 0, cmd_ack);
    assert (led === 3'b000) else report_mismatch("reset_led", 0, led);
  endtask

  task automatic check_sync_timing();
    int n_lo;
    int n_hi;
    cycles_until(1'b0, 1'b1, 1000, n_lo);
    cycles_until(1'b0, 1'b0, 1000, n_lo);  // at an hsync fall
    cycles_until(1'b0, 1'b1, 1000, n_lo);
    cycles_until(1'b0, 1'b0, 1000, n_hi);
    assert (n_lo == h_sync) else report_mismatch("hsync_width", h_sync, n_lo);
    assert (n_lo + n_hi == h_total) else report_mismatch("hsync_period", h_total, n_lo + n_hi);
    cycles_until(1'b1, 1'b1, frame_cycles, n_lo);
    cycles_until(1'b1, 1'b0, frame_cycles, n_lo);
    cycles_until(1'b1, 1'b1, frame_cycles, n_lo);
    cycles_until(1'b1, 1'b0, frame_cycles, n_hi);
    assert (n_lo == 2 * 800) else report_mismatch("vsync_width", 2 * 800, n_lo);
    assert (n_lo + n_hi == frame_cycles)
      else report_mismatch("vsync_period", frame_cycles, n_lo + n_hi);
  endtask

  task automatic check_blanking();
    int hcs [6] = '{400, 400, 10, 100, 790, 400};  // sync, porches
    int vcs [6] = '{0, 20, 80, 80, 80, 515};
    for (int k = 0; k < 6; k++) begin
      wait_pixel(hcs[k], vcs[k]);
      assert (aborted || color == 2'b00) else report_mismatch("blanking", 0, color);
    end
  endtask

  task automatic check_frame_commit();
    int f0;
    wait_pixel(h_start, v_start + 100);  // mid frame, far from the commit
    f0 = out_frame;
    send_cmd(op_center_x, take_bits(9) + 64, "commit_cx");
    send_cmd(op_center_y, take_bits(8) + 100, "commit_cy");
    send_cmd(op_speed, take_bits(7) + 1, "commit_speed");
    sample_grid("commit_old", 200, 479);  // rest of this frame, old settings
    assert (aborted || out_frame == f0) else begin
      proto_errs++;
      $display("old-settings pixels were not all taken from the command frame");
    end
    sample_grid("commit_new", 0, 479);
    assert (aborted || out_frame == f0 + 1) else begin
      proto_errs++;
      $display("new-settings pixels were not taken from the following frame");
    end
  endtask

  task automatic check_freeze_run();
    wait_pixel(h_start, v_start + 100);
    send_cmd(op_freeze, 0, "freeze");
    sample_grid("freeze_a", 0, 479);
    measure_led_duty("freeze_a_led");
    grid_prev = grid_now;
    duty_prev = duty_now;
    sample_grid("freeze_b", 0, 479);
    measure_led_duty("freeze_b_led");
    for (int k = 0; k < 64; k++) begin
      assert (grid_now[k] == grid_prev[k])
        else report_mismatch("freeze_repeat", grid_prev[k], grid_now[k]);
    end
    for (int b = 0; b < 3; b++) begin
      assert (duty_now[b] == duty_prev[b])
        else report_mismatch("freeze_led", duty_prev[b], duty_now[b]);
    end
    wait_pixel(h_start, v_start + 100);
    send_cmd(op_run, 0, "run");
    sample_grid("run_resume", 0, 479);  // phase stepped by the speed again
    measure_led_duty("run_led");
  endtask

  initial begin
    pixclk      = 1'b0;
    reset       = 1'b1;
    cmd_req     = 1'b0;
    cmd_op      = op_nop;
    cmd_data    = '0;
    mismatches  = 0;
    proto_errs  = 0;
    timeouts    = 0;
    aborted     = 1'b0;
    lfsr        = 32'd88425;
    pend_cx     = 320;  // power-up center and speed
    pend_cy     = 240;
    pend_speed  = 1;
    pend_run    = 1'b1;
    act_cx      = 320;
    act_cy      = 240;
    model_phase = 0;
    repeat (3) @(posedge pixclk);
    #1;
    check_reset_outputs();
    #1;
    reset = 1'b0;
    check_sync_timing();
    check_blanking();
    sample_grid("ring_default", 0, 479);
    send_cmd(op_nop, 0, "handshake_nop");
    check_frame_commit();
    check_freeze_run();
    $display("errors: %0d mismatch, %0d protocol, %0d timeout", mismatches, proto_errs,
             timeouts);
    if (mismatches + proto_errs + timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- source/led_dimmer.sv
module led_dimmer import video_timing_pkg::*; (
  input  logic               pixclk,
  input  logic               reset,
  input  logic [phase_w-1:0] phase,
  output logic [2:0]         led     // pwm, one duty field per led
);

  logic [7:0] pwm_cnt;  // free running, period 256 pixclk

  // ------------------------------------------------------------------------
  // pwm compare against three overlapping phase fields
  // ------------------------------------------------------------------------
  // each field one bit higher, so each led breathes at half the rate of
  // the one before it
  always_ff @(posedge pixclk) begin
    if (reset) begin
      pwm_cnt <= '0;
      led     <= 3'b000;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      led[0]  <= (pwm_cnt < phase[12:5]);  // fastest
      led[1]  <= (pwm_cnt < phase[13:6]);
      led[2]  <= (pwm_cnt < phase[14:7]);  // slowest
    end
  end

endmodule

//--- source/ring_render.sv
module ring_render import video_timing_pkg::*; (
  input  logic               pixclk,
  input  logic               reset,
  input  logic [coord_w-1:0] x,
  input  logic [coord_w-1:0] y,
  input  logic               in_zone,
  input  logic               hsync_raw,
  input  logic               vsync_raw,
  input  logic [coord_w-1:0] center_x,
  input  logic [coord_w-1:0] center_y,
  input  logic [phase_w-1:0] phase,
  output logic               hsync,      // render_lat behind hsync_raw
  output logic               vsync,
  output logic [1:0]         color       // {r2[13], r2[12]}, 0 when blanked
);

  // exact signed offsets, one bit wider than a coordinate
  logic signed [coord_w:0] dx_n;
  logic signed [coord_w:0] dy_n;

  // stage 1, offsets sign-extended to r2 width
  logic signed [phase_w-1:0] dx_q;
  logic signed [phase_w-1:0] dy_q;
  logic [phase_w-1:0]        ph_q;    // phase << phase_shift
  logic                      zone_q;
  logic                      hs_q;
  logic                      vs_q;

  logic [phase_w-1:0] r2;  // radius squared minus phase, mod 2^16

  assign dx_n = $signed({1'b0, x}) - $signed({1'b0, center_x});
  assign dy_n = $signed({1'b0, y}) - $signed({1'b0, center_y});

  // ------------------------------------------------------------------------
  // stage 1: offsets and phase term
  // ------------------------------------------------------------------------
  always_ff @(posedge pixclk) begin
    if (reset) begin
      dx_q   <= '0;
      dy_q   <= '0;
      ph_q   <= '0;
      zone_q <= 1'b0;
      hs_q   <= 1'b1;  // sync idles high
      vs_q   <= 1'b1;
    end else begin
      dx_q   <= dx_n;               // sign extends
      dy_q   <= dy_n;
      ph_q   <= phase << phase_shift;
      zone_q <= in_zone;
      hs_q   <= hsync_raw;
      vs_q   <= vsync_raw;
    end
  end

  // low 16 bits of the squares only depend on the low 16 bits of dx, dy
  assign r2 = dx_q * dx_q + dy_q * dy_q - ph_q;

  // ------------------------------------------------------------------------
  // stage 2: ring bits and masking
  // ------------------------------------------------------------------------
  always_ff @(posedge pixclk) begin
    if (reset) begin
      color <= 2'b00;
      hsync <= 1'b1;
      vsync <= 1'b1;
    end else begin
      color <= zone_q ? {r2[13], r2[12]} : 2'b00;  // ring width 4096 in r2
      hsync <= hs_q;
      vsync <= vs_q;
    end
  end

  // blanking holds through the whole pipe
  a_blank_color: assert property (
    @(posedge pixclk) disable iff (reset)
    !$past(in_zone, render_lat) |-> (color == 2'b00)
  );

endmodule

//--- source/vga_timing.sv
module vga_timing import video_timing_pkg::*; (
  input  logic               pixclk,
  input  logic               reset,
  output logic [coord_w-1:0] x,            // hc relative to active start
  output logic [coord_w-1:0] y,            // vc relative to active start
  output logic               in_zone,      // visible pixel
  output logic               hsync_raw,    // active low, undelayed
  output logic               vsync_raw,    // active low, undelayed
  output logic               frame_start   // first cycle of a frame
);

  logic [coord_w-1:0] hc;  // pixel in line, 0 at start of hsync
  logic [coord_w-1:0] vc;  // line in frame, 0 at start of vsync
  logic               h_last;
  logic               v_last;

  assign h_last = (hc == h_total - 1'b1);
  assign v_last = (vc == v_total - 1'b1);

  // ------------------------------------------------------------------------
  // line and frame counters
  // ------------------------------------------------------------------------
  always_ff @(posedge pixclk) begin
    if (reset) begin
      hc <= '0;
      vc <= '0;
    end else if (h_last) begin
      hc <= '0;  // end of line
      if (v_last) begin
        vc <= '0;  // end of frame
      end else begin
        vc <= vc + 1'b1;
      end
    end else begin
      hc <= hc + 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // decode, all combinational from hc/vc
  // ------------------------------------------------------------------------
  assign hsync_raw = (hc >= h_sync);  // low for the first h_sync pixels
  assign vsync_raw = (vc >= v_sync);  // low for the first v_sync lines

  assign x = hc - h_start;  // wraps outside the window, masked by in_zone
  assign y = vc - v_start;

  assign in_zone = (hc >= h_start) && (hc < h_end) &&
                   (vc >= v_start) && (vc < v_end);

  // both counters at zero, same cycle vsync_raw falls
  assign frame_start = (hc == '0) && (vc == '0);

  // counter never escapes the line
  a_hc_range: assert property (
    @(posedge pixclk) disable iff (reset)
    hc < h_total
  );

  // last pixel of last line is always followed by a frame start at line 0
  a_frame_wrap: assert property (
    @(posedge pixclk) disable iff (reset)
    (h_last && v_last) |=> (frame_start && vc == '0)
  );

endmodule

//--- source/vga_top.sv
module vga_top import video_timing_pkg::*, video_cmd_pkg::*; (
  input  logic                  pixclk,
  input  logic                  reset,
  input  logic                  cmd_req,
  input  cmd_op_e               cmd_op,
  input  logic [cmd_data_w-1:0] cmd_data,
  output logic                  cmd_ack,
  output logic                  hsync,    // active low
  output logic                  vsync,    // active low
  output logic [1:0]            color,
  output logic [2:0]            led
);

  // timing to renderer
  logic [coord_w-1:0] x;
  logic [coord_w-1:0] y;
  logic               in_zone;
  logic               hsync_raw;
  logic               vsync_raw;
  logic               frame_start;

  // control to renderer and leds
  logic [coord_w-1:0] center_x;
  logic [coord_w-1:0] center_y;
  logic [phase_w-1:0] phase;

  // ------------------------------------------------------------------------
  // instances
  // ------------------------------------------------------------------------
  vga_timing u_timing (
    .pixclk      (pixclk),
    .reset       (reset),
    .x           (x),
    .y           (y),
    .in_zone     (in_zone),
    .hsync_raw   (hsync_raw),
    .vsync_raw   (vsync_raw),
    .frame_start (frame_start)
  );

  ring_render u_render (
    .pixclk    (pixclk),
    .reset     (reset),
    .x         (x),
    .y         (y),
    .in_zone   (in_zone),
    .hsync_raw (hsync_raw),
    .vsync_raw (vsync_raw),
    .center_x  (center_x),
    .center_y  (center_y),
    .phase     (phase),
    .hsync     (hsync),
    .vsync     (vsync),
    .color     (color)
  );

  video_ctrl u_ctrl (
    .pixclk      (pixclk),
    .reset       (reset),
    .cmd_req     (cmd_req),
    .cmd_op      (cmd_op),
    .cmd_data    (cmd_data),
    .frame_start (frame_start),
    .cmd_ack     (cmd_ack),
    .center_x    (center_x),
    .center_y    (center_y),
    .phase       (phase)
  );

  led_dimmer u_leds (
    .pixclk (pixclk),
    .reset  (reset),
    .phase  (phase),
    .led    (led)
  );

endmodule

//--- source/video_cmd_pkg.sv
package video_cmd_pkg;

  // ------------------------------------------------------------------------
  // command port encoding
  // ------------------------------------------------------------------------
  localparam int cmd_data_w = 10;  // wide enough for a full coordinate
  localparam int speed_w    = 8;   // low bits of cmd_data on op_speed

  typedef enum logic [2:0] {
    op_nop      = 3'd0,  // handshake only, nothing latched
    op_center_x = 3'd1,
    op_center_y = 3'd2,
    op_speed    = 3'd3,  // phase step per frame
    op_freeze   = 3'd4,  // hold phase
    op_run      = 3'd5   // resume phase
  } cmd_op_e;

  // four-phase req/ack states
  typedef enum logic [1:0] {
    st_idle      = 2'd0,  // waiting for req
    st_ack       = 2'd1,  // command latched, raise ack
    st_wait_drop = 2'd2   // ack high until req goes low
  } ctrl_state_e;

  // ------------------------------------------------------------------------
  // power-up settings
  // ------------------------------------------------------------------------
  localparam logic [cmd_data_w-1:0] def_center_x = 10'd320;  // mid screen
  localparam logic [cmd_data_w-1:0] def_center_y = 10'd240;
  localparam logic [speed_w-1:0]    def_speed    = 8'd1;

endpackage

//--- source/video_ctrl.sv
module video_ctrl import video_timing_pkg::*, video_cmd_pkg::*; (
  input  logic                  pixclk,
  input  logic                  reset,
  input  logic                  cmd_req,      // four-phase request from host
  input  cmd_op_e               cmd_op,       // stable while cmd_req high
  input  logic [cmd_data_w-1:0] cmd_data,
  input  logic                  frame_start,  // commit point
  output logic                  cmd_ack,
  output logic [coord_w-1:0]    center_x,     // active ring center
  output logic [coord_w-1:0]    center_y,
  output logic [phase_w-1:0]    phase         // animation phase
);

  ctrl_state_e state;

  // pending settings, copied to the video path at frame start
  logic [cmd_data_w-1:0] pend_cx;
  logic [cmd_data_w-1:0] pend_cy;
  logic [speed_w-1:0]    pend_speed;
  logic                  pend_run;     // 0 means frozen

  // ------------------------------------------------------------------------
  // handshake FSM and command decode
  // ------------------------------------------------------------------------
  always_ff @(posedge pixclk) begin
    if (reset) begin
      state      <= st_idle;
      cmd_ack    <= 1'b0;
      pend_cx    <= def_center_x;
      pend_cy    <= def_center_y;
      pend_speed <= def_speed;
      pend_run   <= 1'b1;  // animation runs out of reset
    end else begin
      case (state)
        st_idle: begin
          if (cmd_req) begin
            state <= st_ack;
            case (cmd_op)  // latch into pending, video path untouched
              op_center_x: pend_cx    <= cmd_data;
              op_center_y: pend_cy    <= cmd_data;
              op_speed:    pend_speed <= cmd_data[speed_w-1:0];
              op_freeze:   pend_run   <= 1'b0;
              op_run:      pend_run   <= 1'b1;
              default:     ;  // op_nop and unused codes
            endcase
          end
        end
        st_ack: begin
          cmd_ack <= 1'b1;  // second edge after req seen
          state   <= st_wait_drop;
        end
        st_wait_drop: begin
          if (!cmd_req) begin
            cmd_ack <= 1'b0;  // host released, close the cycle
            state   <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // frame-start commit and phase accumulator
  // ------------------------------------------------------------------------
  // speed and run only matter on this edge, the phase step uses the
  // values being committed
  always_ff @(posedge pixclk) begin
    if (reset) begin
      center_x <= def_center_x;
      center_y <= def_center_y;
      phase    <= '0;
    end else if (frame_start) begin
      center_x <= pend_cx;  // no mid-frame change, no tearing
      center_y <= pend_cy;
      if (pend_run) begin
        phase <= phase + {{(phase_w - speed_w){1'b0}}, pend_speed};
      end
    end
  end

  // ack only answers a request held across the decode cycle
  a_ack_after_req: assert property (
    @(posedge pixclk) disable iff (reset)
    $rose(cmd_ack) |-> ($past(cmd_req) && $past(cmd_req, 2))
  );

endmodule

//--- source/video_timing_pkg.sv
package video_timing_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------
  localparam int coord_w     = 10;  // hc, vc, x, y
  localparam int phase_w     = 16;  // animation phase
  localparam int phase_shift = 6;   // phase scaling into r2 space
  localparam int render_lat  = 2;   // ring pipeline depth, sync follows it

  // ------------------------------------------------------------------------
  // 640x480 raw timing
  // ------------------------------------------------------------------------
  localparam logic [coord_w-1:0] h_active = 10'd640;
  localparam logic [coord_w-1:0] h_front  = 10'd16;
  localparam logic [coord_w-1:0] h_sync   = 10'd96;
  localparam logic [coord_w-1:0] h_back   = 10'd48;

  localparam logic [coord_w-1:0] v_active = 10'd480;
  localparam logic [coord_w-1:0] v_front  = 10'd11;
  localparam logic [coord_w-1:0] v_sync   = 10'd2;
  localparam logic [coord_w-1:0] v_back   = 10'd28;

  // ------------------------------------------------------------------------
  // derived totals and window edges
  // ------------------------------------------------------------------------
  localparam logic [coord_w-1:0] h_total = h_active + h_front + h_sync + h_back; // 800
  localparam logic [coord_w-1:0] v_total = v_active + v_front + v_sync + v_back; // 521

  // counter origin is the start of sync, so active video follows back porch
  localparam logic [coord_w-1:0] h_start = h_sync + h_back;     // 144
  localparam logic [coord_w-1:0] h_end   = h_start + h_active;  // 784
  localparam logic [coord_w-1:0] v_start = v_sync + v_back;     // 30
  localparam logic [coord_w-1:0] v_end   = v_start + v_active;  // 510

endpackage
